//--- verilog/lockstep_bus_pkg.sv
// ==========================================================================
// Lockstep instruction bus definitions
// Field widths of the OBI-style instruction bus and the WFI opcode
// ==========================================================================

package lockstep_bus_pkg;

    // Default address width of every bus port
    localparam int unsigned ADDR_W = 32;

    // Read data width
    localparam int unsigned DATA_W = 32;

    // RISC-V wfi, fed to parked harts so they go back to sleep
    localparam logic [DATA_W-1:0] WFI_OPCODE = 32'h1050_0073;

endpackage

//--- verilog/redundancy_cfg_pkg.sv
// ==========================================================================
// Redundancy configuration definitions
// Hart count, redundancy mode codes and the mode word with its payload
// ==========================================================================

package redundancy_cfg_pkg;

    // Voting needs exactly three harts
    localparam int unsigned NHARTS = 3;

    // Code 2'b11 is unused and runs as SINGLE
    typedef enum logic [1:0] {
        MODE_SINGLE = 2'b00,
        MODE_TMR    = 2'b01,
        MODE_DMR    = 2'b10
    } mode_e;

    // TMR view of the payload
    typedef struct packed {
        logic [NHARTS-1:0] unused;
        logic [NHARTS-1:0] master;
    } tmr_payload_t;

    // DMR view, master one-hot must sit inside the pair mask
    typedef struct packed {
        logic [NHARTS-1:0] pair;
        logic [NHARTS-1:0] master;
    } dmr_payload_t;

    typedef union packed {
        tmr_payload_t tmr;
        dmr_payload_t dmr;
    } mode_payload_u;

    typedef struct packed {
        mode_e         mode;
        mode_payload_u payload;
    } mode_word_t;

endpackage

//--- verilog/mode_config_reg.sv
// ==========================================================================
// Mode configuration register
// Latches a new mode word, only while every hart is asleep
// ==========================================================================

`timescale 1ns/10ps

module mode_config_reg (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic                                  cfg_load_i,
    input  redundancy_cfg_pkg::mode_word_t        cfg_word_i,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0] sleep_i,
    output redundancy_cfg_pkg::mode_e             mode_o,
    output redundancy_cfg_pkg::mode_payload_u     payload_o
);

    redundancy_cfg_pkg::mode_e         mode_q;
    redundancy_cfg_pkg::mode_payload_u payload_q;
    redundancy_cfg_pkg::mode_e         load_mode;
    logic                              load_en;

    // Master must never change under a running hart
    assign load_en = cfg_load_i & (&sleep_i);

    // Unused code falls back to SINGLE
    always_comb begin
        case (cfg_word_i.mode)
            redundancy_cfg_pkg::MODE_TMR,
            redundancy_cfg_pkg::MODE_DMR: load_mode = cfg_word_i.mode;
            default:                      load_mode = redundancy_cfg_pkg::MODE_SINGLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mode_q                   <= redundancy_cfg_pkg::MODE_SINGLE;
            payload_q.tmr.unused     <= '0;
            // Hart 0 is master out of reset
            payload_q.tmr.master     <= 3'b001;
        end else if (load_en) begin
            mode_q    <= load_mode;
            payload_q <= cfg_word_i.payload;
        end
    end

    assign mode_o    = mode_q;
    assign payload_o = payload_q;

endmodule

//--- verilog/redundancy_checker.sv
// ==========================================================================
// Redundancy checker
// Bitwise majority voter over three harts and a pair comparator for DMR,
// both purely combinational, with their error flags
// ==========================================================================

`timescale 1ns/10ps

module redundancy_checker #(
    parameter int unsigned ADDR_W = lockstep_bus_pkg::ADDR_W
) (
    input  redundancy_cfg_pkg::mode_e                             mode_i,
    input  redundancy_cfg_pkg::mode_payload_u                     payload_i,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0]                 hart_req_i,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0][ADDR_W-1:0]     hart_addr_i,
    output logic                                                  voted_req_o,
    output logic [ADDR_W-1:0]                                     voted_addr_o,
    output logic                                                  pair_req_o,
    output logic [ADDR_W-1:0]                                     pair_addr_o,
    output logic                                                  tmr_error_o,
    output logic [redundancy_cfg_pkg::NHARTS-1:0]                 tmr_error_id_o,
    output logic                                                  dmr_error_o
);

    logic [redundancy_cfg_pkg::NHARTS-1:0] dissent;
    logic                                  tmr_active;
    logic                                  dmr_active;
    logic [1:0]                            pair_a;
    logic [1:0]                            pair_b;
    logic                                  pair_match;
    logic                                  master_req;
    logic [ADDR_W-1:0]                     master_addr;

    assign tmr_active = (mode_i == redundancy_cfg_pkg::MODE_TMR);
    assign dmr_active = (mode_i == redundancy_cfg_pkg::MODE_DMR);

    // 2-of-3 majority, bit by bit
    assign voted_req_o = (hart_req_i[0] & hart_req_i[1])
                       | (hart_req_i[0] & hart_req_i[2])
                       | (hart_req_i[1] & hart_req_i[2]);

    assign voted_addr_o = (hart_addr_i[0] & hart_addr_i[1])
                        | (hart_addr_i[0] & hart_addr_i[2])
                        | (hart_addr_i[1] & hart_addr_i[2]);

    // A hart dissents if any of its request bits disagrees with the vote
    always_comb begin
        for (int i = 0; i < redundancy_cfg_pkg::NHARTS; i++) begin
            dissent[i] = (hart_req_i[i] != voted_req_o)
                       || (hart_addr_i[i] != voted_addr_o);
        end
    end

    assign tmr_error_id_o = tmr_active ? dissent : '0;
    assign tmr_error_o    = |tmr_error_id_o;

    // Pair members from the two set bits of the mask
    always_comb begin
        case (payload_i.dmr.pair)
            3'b101: begin
                pair_a = 2'd0;
                pair_b = 2'd2;
            end
            3'b110: begin
                pair_a = 2'd1;
                pair_b = 2'd2;
            end
            default: begin
                pair_a = 2'd0;
                pair_b = 2'd1;
            end
        endcase
    end

    assign pair_match = (hart_req_i[pair_a] == hart_req_i[pair_b])
                     && (hart_addr_i[pair_a] == hart_addr_i[pair_b]);

    // Master request, selected by its one-hot
    always_comb begin
        master_req  = 1'b0;
        master_addr = '0;
        for (int i = 0; i < redundancy_cfg_pkg::NHARTS; i++) begin
            if (payload_i.dmr.master[i]) begin
                master_req  = master_req | hart_req_i[i];
                master_addr = master_addr | hart_addr_i[i];
            end
        end
    end

    // A mismatching pair never reaches memory
    assign pair_req_o  = master_req & pair_match;
    assign pair_addr_o = master_addr;
    assign dmr_error_o = dmr_active & ~pair_match;

endmodule

//--- verilog/wfi_isolation_responder.sv
// ==========================================================================
// WFI isolation responder
// Stand-in memory for parked harts: grants at once, answers with wfi
// ==========================================================================

`timescale 1ns/10ps

module wfi_isolation_responder (
    input  logic                                                         clk_i,
    input  logic                                                         rst_ni,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0]                        req_i,
    output logic [redundancy_cfg_pkg::NHARTS-1:0]                        gnt_o,
    output logic [redundancy_cfg_pkg::NHARTS-1:0]                        rvalid_o,
    output logic [redundancy_cfg_pkg::NHARTS-1:0][lockstep_bus_pkg::DATA_W-1:0] rdata_o
);

    logic [redundancy_cfg_pkg::NHARTS-1:0] rvalid_q;

    // Never any back-pressure
    assign gnt_o = req_i;

    // One response per granted cycle, one cycle later
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= '0;
        end else begin
            rvalid_q <= gnt_o;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = {redundancy_cfg_pkg::NHARTS{lockstep_bus_pkg::WFI_OPCODE}};

endmodule

//--- verilog/bus_router.sv
// ==========================================================================
// Instruction bus router
// Steers hart, voted or pair requests onto the memory ports and fans the
// responses back out according to the active redundancy mode
// ==========================================================================

`timescale 1ns/10ps

module bus_router #(
    parameter int unsigned ADDR_W = lockstep_bus_pkg::ADDR_W
) (
    input  logic                                                      clk_i,
    input  logic                                                      rst_ni,
    input  redundancy_cfg_pkg::mode_e                                 mode_i,
    input  redundancy_cfg_pkg::mode_payload_u                         payload_i,
    input  logic                                                      isolate_i,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0]                     hart_req_i,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0][ADDR_W-1:0]         hart_addr_i,
    input  logic                                                      voted_req_i,
    input  logic [ADDR_W-1:0]                                         voted_addr_i,
    input  logic                                                      pair_req_i,
    input  logic [ADDR_W-1:0]                                         pair_addr_i,
    output logic [redundancy_cfg_pkg::NHARTS-1:0]                     mem_req_o,
    output logic [redundancy_cfg_pkg::NHARTS-1:0][ADDR_W-1:0]         mem_addr_o,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0]                     mem_gnt_i,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0]                     mem_rvalid_i,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0][lockstep_bus_pkg::DATA_W-1:0] mem_rdata_i,
    output logic [redundancy_cfg_pkg::NHARTS-1:0]                     hart_gnt_o,
    output logic [redundancy_cfg_pkg::NHARTS-1:0]                     hart_rvalid_o,
    output logic [redundancy_cfg_pkg::NHARTS-1:0][lockstep_bus_pkg::DATA_W-1:0] hart_rdata_o
);

    logic [redundancy_cfg_pkg::NHARTS-1:0]                           master;
    logic [redundancy_cfg_pkg::NHARTS-1:0]                           isolated;
    logic                                                            m_gnt;
    logic                                                            m_rvalid;
    logic [lockstep_bus_pkg::DATA_W-1:0]                             m_rdata;
    logic [redundancy_cfg_pkg::NHARTS-1:0]                           iso_gnt;
    logic [redundancy_cfg_pkg::NHARTS-1:0]                           iso_rvalid;
    logic [redundancy_cfg_pkg::NHARTS-1:0][lockstep_bus_pkg::DATA_W-1:0] iso_rdata;

    // Master one-hot sits in the same bits in both payload views
    assign master = payload_i.tmr.master;

    assign isolated = (mode_i == redundancy_cfg_pkg::MODE_DMR && isolate_i)
                    ? payload_i.dmr.pair : '0;

    // Parked pair fetches land here instead of on memory
    wfi_isolation_responder wfi_isolation_responder_i (
        .clk_i,
        .rst_ni,
        .req_i   (hart_req_i & isolated),
        .gnt_o   (iso_gnt),
        .rvalid_o(iso_rvalid),
        .rdata_o (iso_rdata)
    );

    // Response of the master port for the harts behind it
    always_comb begin
        m_gnt    = 1'b0;
        m_rvalid = 1'b0;
        m_rdata  = '0;
        for (int i = 0; i < redundancy_cfg_pkg::NHARTS; i++) begin
            if (master[i]) begin
                m_gnt    = m_gnt | mem_gnt_i[i];
                m_rvalid = m_rvalid | mem_rvalid_i[i];
                m_rdata  = m_rdata | mem_rdata_i[i];
            end
        end
    end

    always_comb begin
        // SINGLE puts every hart on its own port
        mem_req_o     = hart_req_i;
        mem_addr_o    = hart_addr_i;
        hart_gnt_o    = mem_gnt_i;
        hart_rvalid_o = mem_rvalid_i;
        hart_rdata_o  = mem_rdata_i;

        for (int i = 0; i < redundancy_cfg_pkg::NHARTS; i++) begin
            case (mode_i)
                redundancy_cfg_pkg::MODE_TMR: begin
                    mem_req_o[i]     = master[i] & voted_req_i;
                    mem_addr_o[i]    = master[i] ? voted_addr_i : '0;
                    hart_gnt_o[i]    = m_gnt;
                    hart_rvalid_o[i] = m_rvalid;
                    hart_rdata_o[i]  = m_rdata;
                end
                redundancy_cfg_pkg::MODE_DMR: begin
                    if (isolated[i]) begin
                        mem_req_o[i]     = 1'b0;
                        mem_addr_o[i]    = '0;
                        hart_gnt_o[i]    = iso_gnt[i];
                        hart_rvalid_o[i] = iso_rvalid[i];
                        hart_rdata_o[i]  = iso_rdata[i];
                    end else if (payload_i.dmr.pair[i]) begin
                        mem_req_o[i]     = master[i] & pair_req_i;
                        mem_addr_o[i]    = master[i] ? pair_addr_i : '0;
                        hart_gnt_o[i]    = m_gnt;
                        hart_rvalid_o[i] = m_rvalid;
                        hart_rdata_o[i]  = m_rdata;
                    end
                    // Third hart keeps its own port
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- verilog/safe_bus_wrapper.sv
// ==========================================================================
// Safety bus wrapper
// Instruction bus multiplexer of a triple-core lockstep system: mode
// latch, voter and comparator, and the port router
// ==========================================================================

`timescale 1ns/10ps

module safe_bus_wrapper #(
    parameter int unsigned ADDR_W = lockstep_bus_pkg::ADDR_W
) (
    input  logic                                                      clk_i,
    input  logic                                                      rst_ni,

    // Hart side
    input  logic [redundancy_cfg_pkg::NHARTS-1:0]                     hart_req_i,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0][ADDR_W-1:0]         hart_addr_i,
    output logic [redundancy_cfg_pkg::NHARTS-1:0]                     hart_gnt_o,
    output logic [redundancy_cfg_pkg::NHARTS-1:0]                     hart_rvalid_o,
    output logic [redundancy_cfg_pkg::NHARTS-1:0][lockstep_bus_pkg::DATA_W-1:0] hart_rdata_o,

    // Memory side
    output logic [redundancy_cfg_pkg::NHARTS-1:0]                     mem_req_o,
    output logic [redundancy_cfg_pkg::NHARTS-1:0][ADDR_W-1:0]         mem_addr_o,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0]                     mem_gnt_i,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0]                     mem_rvalid_i,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0][lockstep_bus_pkg::DATA_W-1:0] mem_rdata_i,

    // Configuration
    input  logic                                                      cfg_load_i,
    input  redundancy_cfg_pkg::mode_word_t                            cfg_word_i,
    input  logic [redundancy_cfg_pkg::NHARTS-1:0]                     sleep_i,
    input  logic                                                      isolate_i,

    // Errors
    output logic                                                      tmr_error_o,
    output logic [redundancy_cfg_pkg::NHARTS-1:0]                     tmr_error_id_o,
    output logic                                                      dmr_error_o
);

    redundancy_cfg_pkg::mode_e         mode;
    redundancy_cfg_pkg::mode_payload_u payload;
    logic                              voted_req;
    logic [ADDR_W-1:0]                 voted_addr;
    logic                              pair_req;
    logic [ADDR_W-1:0]                 pair_addr;

    mode_config_reg mode_config_reg_i (
        .clk_i,
        .rst_ni,
        .cfg_load_i,
        .cfg_word_i,
        .sleep_i,
        .mode_o   (mode),
        .payload_o(payload)
    );

    redundancy_checker #(
        .ADDR_W(ADDR_W)
    ) redundancy_checker_i (
        .mode_i        (mode),
        .payload_i     (payload),
        .hart_req_i,
        .hart_addr_i,
        .voted_req_o   (voted_req),
        .voted_addr_o  (voted_addr),
        .pair_req_o    (pair_req),
        .pair_addr_o   (pair_addr),
        .tmr_error_o,
        .tmr_error_id_o,
        .dmr_error_o
    );

    bus_router #(
        .ADDR_W(ADDR_W)
    ) bus_router_i (
        .clk_i,
        .rst_ni,
        .mode_i      (mode),
        .payload_i   (payload),
        .isolate_i,
        .hart_req_i,
        .hart_addr_i,
        .voted_req_i (voted_req),
        .voted_addr_i(voted_addr),
        .pair_req_i  (pair_req),
        .pair_addr_i (pair_addr),
        .mem_req_o,
        .mem_addr_o,
        .mem_gnt_i,
        .mem_rvalid_i,
        .mem_rdata_i,
        .hart_gnt_o,
        .hart_rvalid_o,
        .hart_rdata_o
    );

endmodule

//--- test/tb_clock_gen.sv
// ==========================================================================
// Testbench clock and reset
// Free-running clock and an active-low reset held for a few cycles
// ==========================================================================

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release just after an edge, clear of the sampling point
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

//--- test/safe_bus_wrapper_asserts.sv
// ==========================================================================
// Safety bus wrapper assertions
// Port exclusivity in TMR, isolation response timing, quiet errors in SINGLE
// ==========================================================================

`timescale 1ns/10ps

module safe_bus_wrapper_asserts (
    input logic                                  clk_i,
    input logic                                  rst_ni,
    input redundancy_cfg_pkg::mode_e             mode_i,
    input redundancy_cfg_pkg::mode_payload_u     payload_i,
    input logic                                  isolate_i,
    input logic [redundancy_cfg_pkg::NHARTS-1:0] hart_req_i,
    input logic [redundancy_cfg_pkg::NHARTS-1:0] hart_gnt_i,
    input logic [redundancy_cfg_pkg::NHARTS-1:0] hart_rvalid_i,
    input logic [redundancy_cfg_pkg::NHARTS-1:0] mem_req_i,
    input logic                                  tmr_error_i,
    input logic                                  dmr_error_i
);

    logic [redundancy_cfg_pkg::NHARTS-1:0] iso_gnt;

    // Grants handed out by the local responder
    assign iso_gnt = (mode_i == redundancy_cfg_pkg::MODE_DMR && isolate_i)
                   ? (payload_i.dmr.pair & hart_req_i & hart_gnt_i) : '0;

    tmr_single_port: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mode_i == redundancy_cfg_pkg::MODE_TMR |-> $onehot0(mem_req_i))
        else $error("more than one memory port requests in TMR mode");

    iso_rvalid_next: assert property (@(posedge clk_i) disable iff (!rst_ni)
        iso_gnt != '0 |=> !isolate_i || ((hart_rvalid_i & $past(iso_gnt)) == $past(iso_gnt)))
        else $error("isolated grant not followed by rvalid one cycle later");

    single_no_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mode_i == redundancy_cfg_pkg::MODE_SINGLE |-> !tmr_error_i && !dmr_error_i)
        else $error("error flag raised in SINGLE mode");

endmodule

bind safe_bus_wrapper safe_bus_wrapper_asserts asserts_i (
    .clk_i,
    .rst_ni,
    .mode_i       (mode),
    .payload_i    (payload),
    .isolate_i,
    .hart_req_i,
    .hart_gnt_i   (hart_gnt_o),
    .hart_rvalid_i(hart_rvalid_o),
    .mem_req_i    (mem_req_o),
    .tmr_error_i  (tmr_error_o),
    .dmr_error_i  (dmr_error_o)
);

//--- test/safe_bus_wrapper_tb.sv
// ==========================================================================
// Safety bus wrapper testbench
// Random fetches in every redundancy mode against a reference routing model
// ==========================================================================

`timescale 1ns/10ps

module safe_bus_wrapper_tb;

    localparam int N          = redundancy_cfg_pkg::NHARTS;
    localparam int AW         = lockstep_bus_pkg::ADDR_W;
    localparam int DW         = lockstep_bus_pkg::DATA_W;
    localparam int CW         = N * DW;
    localparam int CLK_PERIOD = 100;
    // Reset, five loads, hart traffic of all phases and the closing cycles
    localparam int TEST_CYCLES = 2 + 5 * 2 + 20 + 4 + 44 + 30 + 20 + 1 + 15 + 15 + 2;

    logic                 clk, rst_n, cfg_load, isolate;
    logic [N-1:0]         hart_req, hart_gnt, hart_rvalid, sleep, mem_req, mem_gnt, mem_rvalid;
    logic [N-1:0][AW-1:0] hart_addr, mem_addr, exp_addr, mem_addr_q;
    logic [N-1:0][DW-1:0] hart_rdata, mem_rdata, exp_rdata;
    logic                 tmr_error, dmr_error, exp_tmr_err, exp_dmr_err;
    logic [N-1:0]         tmr_error_id, exp_tmr_id, exp_req, exp_gnt, exp_rvalid;
    logic [N-1:0]         iso_pending, mem_granted;
    logic [31:0]          mem_draw;
    redundancy_cfg_pkg::mode_word_t cfg_word, model_word;
    int                   errors = 0;
    int                   checks = 0;
    integer               seed   = 32'hf44ba8d0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(2)) clock_gen_i (
        .clk_o(clk), .rst_no(rst_n)
    );

    safe_bus_wrapper #(.ADDR_W(AW)) dut_i (
        .clk_i(clk), .rst_ni(rst_n),
        .hart_req_i(hart_req), .hart_addr_i(hart_addr), .hart_gnt_o(hart_gnt),
        .hart_rvalid_o(hart_rvalid), .hart_rdata_o(hart_rdata),
        .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_gnt_i(mem_gnt),
        .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata),
        .cfg_load_i(cfg_load), .cfg_word_i(cfg_word), .sleep_i(sleep), .isolate_i(isolate),
        .tmr_error_o(tmr_error), .tmr_error_id_o(tmr_error_id), .dmr_error_o(dmr_error)
    );

    task automatic check_value(input string name, input logic [CW-1:0] got,
                               input logic [CW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Reference routing, vote and compare rules for the current cycle
    function automatic void compute_expected();
        logic [N-1:0]  dissent;
        logic [AW-1:0] vote_addr;
        logic          vote_req;
        logic          match;
        int            m;
        int            pa;
        int            pb;
        int            ones;
        exp_req = hart_req;
        exp_addr = hart_addr;
        exp_gnt = mem_gnt;
        exp_rvalid = mem_rvalid;
        exp_rdata = mem_rdata;
        exp_tmr_err = 1'b0;
        exp_tmr_id = '0;
        exp_dmr_err = 1'b0;
        m = 0;
        pa = -1;
        pb = -1;
        ones = 0;
        case (model_word.mode)
            redundancy_cfg_pkg::MODE_TMR: begin
                for (int h = 0; h < N; h++) begin
                    if (model_word.payload.tmr.master[h]) m = h;
                    if (hart_req[h]) ones++;
                end
                vote_req = (ones >= 2);
                // Majority of each address bit by counting
                for (int b = 0; b < AW; b++) begin
                    ones = 0;
                    for (int h = 0; h < N; h++) begin
                        if (hart_addr[h][b]) ones++;
                    end
                    vote_addr[b] = (ones >= 2);
                end
                for (int h = 0; h < N; h++) begin
                    dissent[h] = (hart_req[h] != vote_req) || (hart_addr[h] != vote_addr);
                    exp_req[h] = (h == m) && vote_req;
                    exp_addr[h] = (h == m) ? vote_addr : '0;
                    exp_gnt[h] = mem_gnt[m];
                    exp_rvalid[h] = mem_rvalid[m];
                    exp_rdata[h] = mem_rdata[m];
                end
                exp_tmr_id = dissent;
                exp_tmr_err = |dissent;
            end
            redundancy_cfg_pkg::MODE_DMR: begin
                for (int h = 0; h < N; h++) begin
                    if (model_word.payload.dmr.master[h]) m = h;
                    if (model_word.payload.dmr.pair[h] && pa < 0) pa = h;
                    else if (model_word.payload.dmr.pair[h]) pb = h;
                end
                match = (hart_req[pa] == hart_req[pb]) && (hart_addr[pa] == hart_addr[pb]);
                exp_dmr_err = !match;
                for (int h = 0; h < N; h++) begin
                    if (model_word.payload.dmr.pair[h]) begin
                        exp_req[h] = !isolate && (h == m) && hart_req[m] && match;
                        exp_addr[h] = (!isolate && h == m) ? hart_addr[m] : '0;
                        exp_gnt[h] = isolate ? hart_req[h] : mem_gnt[m];
                        exp_rvalid[h] = isolate ? iso_pending[h] : mem_rvalid[m];
                        exp_rdata[h] = isolate ? lockstep_bus_pkg::WFI_OPCODE : mem_rdata[m];
                    end
                end
            end
            default: begin
            end
        endcase
    endfunction

    // Compare at the falling edge, where every output has settled
    initial begin
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                model_word = {redundancy_cfg_pkg::MODE_SINGLE, 6'b000_001};
                iso_pending = '0;
            end else begin
                compute_expected();
                check_value("mem_req_o", CW'(mem_req), CW'(exp_req));
                check_value("mem_addr_o", CW'(mem_addr), CW'(exp_addr));
                check_value("hart_gnt_o", CW'(hart_gnt), CW'(exp_gnt));
                check_value("hart_rvalid_o", CW'(hart_rvalid), CW'(exp_rvalid));
                check_value("hart_rdata_o", CW'(hart_rdata), CW'(exp_rdata));
                check_value("tmr_error_o", CW'(tmr_error), CW'(exp_tmr_err));
                check_value("tmr_error_id_o", CW'(tmr_error_id), CW'(exp_tmr_id));
                check_value("dmr_error_o", CW'(dmr_error), CW'(exp_dmr_err));
                iso_pending = (model_word.mode == redundancy_cfg_pkg::MODE_DMR && isolate)
                            ? (hart_req & model_word.payload.dmr.pair) : '0;
                // Accepted load is active from the next cycle
                if (cfg_load && &sleep) begin
                    model_word = cfg_word;
                    if (cfg_word.mode == 2'b11) model_word.mode = redundancy_cfg_pkg::MODE_SINGLE;
                end
            end
        end
    end

    // Memory: random grant, data one cycle after each granted cycle
    initial begin
        forever begin
            @(negedge clk);
            mem_granted = mem_req & mem_gnt;
            mem_addr_q = mem_addr;
            mem_draw = $random(seed);
            @(posedge clk);
            #1;
            mem_gnt = mem_draw[N-1:0];
            mem_rvalid = mem_granted;
            for (int p = 0; p < N; p++) begin
                mem_rdata[p] = mem_addr_q[p] + p;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Harts in same_mask fetch in lockstep, corrupt flips address bits of one hart
    task automatic drive_harts(input int cycles, input logic [N-1:0] same_mask, input int corrupt);
        logic [31:0]   r;
        logic [AW-1:0] base;
        logic          base_req;
        repeat (cycles) begin
            next_cycle();
            r = $random(seed);
            base_req = r[0];
            base = $random(seed);
            for (int h = 0; h < N; h++) begin
                r = $random(seed);
                hart_req[h] = same_mask[h] ? base_req : r[0];
                hart_addr[h] = same_mask[h] ? base : $random(seed);
            end
            if (corrupt >= 0) begin
                r = $random(seed);
                hart_addr[corrupt] = hart_addr[corrupt] ^ (r | 32'h1);
            end
        end
    endtask

    task automatic load_word(input redundancy_cfg_pkg::mode_word_t word, input logic [N-1:0] asleep);
        next_cycle();
        hart_req = '0;
        sleep = asleep;
        cfg_word = word;
        cfg_load = 1'b1;
        next_cycle();
        cfg_load = 1'b0;
        sleep = '0;
    endtask

    initial begin
        hart_req = '0;
        hart_addr = '0;
        mem_gnt = '0;
        mem_rvalid = '0;
        mem_rdata = '0;
        cfg_load = 1'b0;
        cfg_word = '0;
        sleep = '0;
        isolate = 1'b0;
        @(posedge rst_n);
        drive_harts(20, 3'b000, -1);
        // Hart 2 awake, so this load must be dropped
        load_word({redundancy_cfg_pkg::MODE_TMR, 6'b000_010}, 3'b011);
        drive_harts(4, 3'b000, -1);
        load_word({redundancy_cfg_pkg::MODE_TMR, 6'b000_010}, 3'b111);
        drive_harts(20, 3'b111, -1);
        for (int h = 0; h < N; h++) begin
            drive_harts(8, 3'b111, h);
        end
        // Pair of harts 0 and 2 with master 2, hart 1 alone
        load_word({redundancy_cfg_pkg::MODE_DMR, 6'b101_100}, 3'b111);
        drive_harts(20, 3'b101, -1);
        drive_harts(10, 3'b101, 0);
        isolate = 1'b1;
        drive_harts(20, 3'b101, -1);
        next_cycle();
        isolate = 1'b0;
        hart_req = '0;
        load_word({redundancy_cfg_pkg::MODE_DMR, 6'b011_001}, 3'b111);
        drive_harts(15, 3'b011, -1);
        // Unused mode code runs as SINGLE
        load_word({2'b11, 6'b000_100}, 3'b111);
        drive_harts(15, 3'b000, -1);
        next_cycle();
        next_cycle();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + 20) * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in time");
        $display("%0d checks, %0d errors", checks, errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- safe_bus_wrapper.f
verilog/lockstep_bus_pkg.sv
verilog/redundancy_cfg_pkg.sv
verilog/mode_config_reg.sv
verilog/redundancy_checker.sv
verilog/wfi_isolation_responder.sv
verilog/bus_router.sv
verilog/safe_bus_wrapper.sv
test/tb_clock_gen.sv
test/safe_bus_wrapper_asserts.sv
test/safe_bus_wrapper_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the safety bus wrapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module safe_bus_wrapper_tb \
    -f safe_bus_wrapper.f \
    -o safe_bus_wrapper_sim

./obj_dir/safe_bus_wrapper_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
exit 1
